/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       := granuleDecoderTb
FILELIST  := sim.f

SOURCES   := $(shell grep -v '^+' $(FILELIST))
BIN       := obj_dir/V$(TOP)

.PHONY: all run clean

all: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

run: $(BIN) tb/granuleGolden.mem
	./$(BIN) | tee /dev/stderr | grep -qx "test passed"

clean:
	rm -rf obj_dir

/* hw/bitReservoir.sv */
// Bit reservoir
`timescale 1ns/1ps
`default_nettype none

module bitReservoir
  import decoderBusPkg::*;
(
  input  logic        Clk,
  input  logic        rst,
  output logic        fetchReq,
  input  logic        fetchAck,
  input  logic [7:0]  fetchData,
  input  bitTake_t    take,
  output logic [15:0] window,
  output logic        windowValid
);

  logic [31:0] shiftReg;     // held bits start at bit 31
  logic [5:0]  fillCount;
  logic [31:0] shifted;
  logic [5:0]  keptCount;
  logic [31:0] keepMask;
  logic [31:0] byteAligned;
  logic        append;

  assign append = fetchReq && fetchAck;

  // ************************************************************************
  // take first, then the new byte goes right below what is left
  // ************************************************************************
  always_comb
  begin
    if (take.take)
    begin
      shifted   = shiftReg << take.count;
      keptCount = fillCount - {1'b0, take.count};
    end
    else
    begin
      shifted   = shiftReg;
      keptCount = fillCount;
    end
    keepMask    = ~(32'hffff_ffff >> keptCount);
    byteAligned = {fetchData, 24'h000000} >> keptCount;
  end

  always_ff @(posedge Clk)
  begin
    if (append)
      shiftReg <= (shifted & keepMask) | byteAligned;
    else
      shiftReg <= shifted;
  end

  always_ff @(posedge Clk)
  begin
    if (rst)
      fillCount <= '0;
    else if (append)
      fillCount <= keptCount + 6'd8;
    else
      fillCount <= keptCount;
  end

  // ************************************************************************
  // four-phase fetch
  // ************************************************************************
  always_ff @(posedge Clk)
  begin
    if (rst)
      fetchReq <= 1'b0;
    else if (append)
      fetchReq <= 1'b0;                                  // byte taken
    else if (!fetchReq && !fetchAck && fillCount < 6'd24)
      fetchReq <= 1'b1;                                  // ack seen low again
  end

  assign window      = shiftReg[31:16];
  assign windowValid = fillCount >= 6'd16;

endmodule

`default_nettype wire

/* hw/count1Decoder.sv */
// Count1 region decoder
`timescale 1ns/1ps
`default_nettype none

module count1Decoder
  import mp3FormatPkg::*;
  import decoderBusPkg::*;
#(
  parameter int sampleWidth   = 16,
  parameter int lineAddrWidth = 10
)
(
  input  logic        Clk,
  input  logic        rst,
  input  logic        start,
  input  logic        channel,
  input  logic [11:0] bitsLeft,
  input  logic [15:0] window,
  input  logic        windowValid,
  output bitTake_t    take,
  output memWr_t      wr,
  output logic        done
);

  typedef enum logic [1:0] {c1Idle, c1Quad, c1Vals, c1Fill} c1State_t;

  localparam logic [lineAddrWidth-1:0] lastLine = lineAddrWidth'(numLines - 1);
  localparam logic [lineAddrWidth-1:0] endLine  = lineAddrWidth'(numLines);

  c1State_t                 state;
  logic [lineAddrWidth-1:0] line;
  logic [3:0]               vwxy;
  logic [1:0]               idx;
  logic                     cur;
  logic                     needSign;
  logic                     quadGo;
  logic                     emit;
  logic [sampleWidth-1:0]   sample;

  assign quadGo   = line < endLine && bitsLeft >= 12'd4;
  assign cur      = vwxy[2'd3 - idx];                   // v first
  assign needSign = cur && bitsLeft != 12'd0;
  assign emit     = (state == c1Vals && (!needSign || windowValid)) || state == c1Fill;

  always_comb
  begin
    if (state == c1Fill || !cur)
      sample = '0;
    else if (needSign && window[15])
      sample = '1;                   // -1
    else
      sample = sampleWidth'(1);
  end

  always_comb
  begin
    take = '0;
    if (state == c1Quad && quadGo && windowValid)
    begin
      take.take  = 1'b1;
      take.count = 5'd4;
    end
    else if (state == c1Vals && needSign && windowValid)
    begin
      take.take  = 1'b1;
      take.count = 5'd1;
    end
  end

  always_comb
  begin
    wr.valid = emit;
    wr.addr  = {1'b0, channel, line};
    wr.data  = sample;
  end

  // ************************************************************************
  // quads, then zero fill to the last line
  // ************************************************************************
  always_ff @(posedge Clk)
  begin
    if (rst)
    begin
      state <= c1Idle;
      done  <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      case (state)
        c1Idle:
          if (start)
            state <= c1Quad;
        c1Quad:
          if (quadGo)
          begin
            if (windowValid)
              state <= c1Vals;
          end
          else if (line == endLine)
          begin
            state <= c1Idle;
            done  <= 1'b1;
          end
          else
            state <= c1Fill;
        c1Vals:
          if (emit && idx == 2'd3)
            state <= c1Quad;
        c1Fill:
          if (line == lastLine)
          begin
            state <= c1Idle;
            done  <= 1'b1;
          end
        default:
          state <= c1Idle;
      endcase
    end
  end

  always_ff @(posedge Clk)
  begin
    if (state == c1Idle && start)
      line <= '0;
    else if (emit)
      line <= line + 1'b1;
    if (state == c1Quad && take.take)
    begin
      vwxy <= ~window[15:12];        // table B
      idx  <= 2'd0;
    end
    else if (emit)
      idx <= idx + 2'd1;
  end

endmodule

`default_nettype wire

/* hw/decoderBusPkg.sv */
// Decoder internal bus types
`default_nettype none

package decoderBusPkg;

  localparam int memAddrWidth = 12;

  // bits consumed from the look-ahead window
  typedef struct packed {
    logic       take;
    logic [4:0] count;  // 0 to 16
  } bitTake_t;

  // addr[11] set for a scalefactor, addr[10] channel,
  // low bits line number or sfb
  typedef struct packed {
    logic                    valid;
    logic [memAddrWidth-1:0] addr;
    logic [15:0]             data;   // two's complement
  } memWr_t;

endpackage

`default_nettype wire

/* hw/granuleSequencer.sv */
// Granule sequencer
`timescale 1ns/1ps
`default_nettype none

module granuleSequencer
  import mp3FormatPkg::*;
  import decoderBusPkg::*;
(
  input  logic        Clk,
  input  logic        rst,
  input  logic        startReq,
  output logic        doneAck,
  input  sideInfo_t   side,
  input  bitTake_t    sfTake,
  input  bitTake_t    c1Take,
  input  memWr_t      sfWr,
  input  memWr_t      c1Wr,
  input  logic        sfDone,
  input  logic        c1Done,
  output logic        sfStart,
  output logic        c1Start,
  output logic [11:0] bitsLeft,
  input  logic        windowValid,
  output bitTake_t    take,
  output memWr_t      memWr
);

  typedef enum logic [2:0] {phIdle, phScale, phCount1, phDiscard, phAck} phase_t;

  phase_t   phase;
  bitTake_t discardTake;
  memWr_t   wrSel;

  // drop leftover part2_3 bits, up to 16 a cycle
  always_comb
  begin
    discardTake.take  = windowValid && bitsLeft != 12'd0;
    discardTake.count = (bitsLeft >= 12'd16) ? 5'd16 : bitsLeft[4:0];
  end

  always_comb
  begin
    take  = '0;
    wrSel = '0;
    case (phase)
      phScale:
      begin
        take  = sfTake;
        wrSel = sfWr;
      end
      phCount1:
      begin
        take  = c1Take;
        wrSel = c1Wr;
      end
      phDiscard:
        take = discardTake;
      default:
        take = '0;
    endcase
  end

  always_ff @(posedge Clk)
  begin
    if (rst)
    begin
      phase   <= phIdle;
      doneAck <= 1'b0;
      sfStart <= 1'b0;
      c1Start <= 1'b0;
    end
    else
    begin
      sfStart <= 1'b0;
      c1Start <= 1'b0;
      case (phase)
        phIdle:
          if (startReq)
          begin
            phase   <= phScale;
            sfStart <= 1'b1;
          end
        phScale:
          if (sfDone)
          begin
            phase   <= phCount1;
            c1Start <= 1'b1;
          end
        phCount1:
          if (c1Done)
            phase <= phDiscard;
        phDiscard:
          if (bitsLeft == 12'd0)
          begin
            phase   <= phAck;
            doneAck <= 1'b1;
          end
        phAck:
          if (!startReq)             // host released
          begin
            phase   <= phIdle;
            doneAck <= 1'b0;
          end
        default:
          phase <= phIdle;
      endcase
    end
  end

  // bit budget of the granule
  always_ff @(posedge Clk)
  begin
    if (rst)
      bitsLeft <= '0;
    else if (phase == phIdle && startReq)
      bitsLeft <= side.part23Length;
    else if (take.take)
      bitsLeft <= bitsLeft - 12'(take.count);
  end

  always_ff @(posedge Clk)
  begin
    if (rst)
      memWr <= '0;
    else
      memWr <= wrSel;
  end

endmodule

`default_nettype wire

/* hw/mp3FormatPkg.sv */
// Layer III format definitions
`default_nettype none

package mp3FormatPkg;

  localparam int numLines   = 576;  // spectral lines per granule
  localparam int numLongSfb = 21;

  typedef struct packed {
    logic        granule;
    logic        channel;
    logic [11:0] part23Length;
    logic [3:0]  scalefacCompress;
    logic [3:0]  scfsi;             // bit 0 covers bands 0..5
  } sideInfo_t;

  typedef struct packed {
    logic [2:0] slen0;  // bands 0..10
    logic [2:0] slen1;  // bands 11..20
  } slenPair_t;

  // standard scalefac_compress table
  function automatic slenPair_t slenPair(input logic [3:0] compress);
    slenPair_t pair;
    case (compress)
      4'd0:    pair = '{3'd0, 3'd0};
      4'd1:    pair = '{3'd0, 3'd1};
      4'd2:    pair = '{3'd0, 3'd2};
      4'd3:    pair = '{3'd0, 3'd3};
      4'd4:    pair = '{3'd3, 3'd0};
      4'd5:    pair = '{3'd1, 3'd1};
      4'd6:    pair = '{3'd1, 3'd2};
      4'd7:    pair = '{3'd1, 3'd3};
      4'd8:    pair = '{3'd2, 3'd1};
      4'd9:    pair = '{3'd2, 3'd2};
      4'd10:   pair = '{3'd2, 3'd3};
      4'd11:   pair = '{3'd3, 3'd1};
      4'd12:   pair = '{3'd3, 3'd2};
      4'd13:   pair = '{3'd3, 3'd3};
      4'd14:   pair = '{3'd4, 3'd2};
      default: pair = '{3'd4, 3'd3};
    endcase
    return pair;
  endfunction

endpackage

`default_nettype wire

/* hw/mp3GranuleDecoder.sv */
// MP3 granule decoder top
`timescale 1ns/1ps
`default_nettype none

module mp3GranuleDecoder
  import mp3FormatPkg::*;
  import decoderBusPkg::*;
#(
  parameter int sampleWidth   = 16,
  parameter int lineAddrWidth = 10
)
(
  input  logic       Clk,
  input  logic       rst,
  input  logic       startReq,
  input  sideInfo_t  side,
  output logic       doneAck,
  output logic       fetchReq,
  input  logic       fetchAck,
  input  logic [7:0] fetchData,
  output memWr_t     memWr
);

  logic [15:0] window;
  logic        windowValid;
  logic [11:0] bitsLeft;
  logic        sfStart;
  logic        sfDone;
  logic        c1Start;
  logic        c1Done;
  bitTake_t    take;
  bitTake_t    sfTake;
  bitTake_t    c1Take;
  memWr_t      sfWr;
  memWr_t      c1Wr;

  bitReservoir reservoir (
    .Clk(Clk), .rst(rst),
    .fetchReq(fetchReq), .fetchAck(fetchAck), .fetchData(fetchData),
    .take(take), .window(window), .windowValid(windowValid)
  );

  scaleFactorParser #(.lineAddrWidth(lineAddrWidth)) sfParser (
    .Clk(Clk), .rst(rst), .start(sfStart), .side(side),
    .window(window), .windowValid(windowValid),
    .take(sfTake), .wr(sfWr), .done(sfDone)
  );

  count1Decoder #(.sampleWidth(sampleWidth), .lineAddrWidth(lineAddrWidth)) c1Dec (
    .Clk(Clk), .rst(rst), .start(c1Start), .channel(side.channel), .bitsLeft(bitsLeft),
    .window(window), .windowValid(windowValid),
    .take(c1Take), .wr(c1Wr), .done(c1Done)
  );

  granuleSequencer sequencer (
    .Clk(Clk), .rst(rst), .startReq(startReq), .doneAck(doneAck), .side(side),
    .sfTake(sfTake), .c1Take(c1Take), .sfWr(sfWr), .c1Wr(c1Wr),
    .sfDone(sfDone), .c1Done(c1Done), .sfStart(sfStart), .c1Start(c1Start),
    .bitsLeft(bitsLeft), .windowValid(windowValid), .take(take), .memWr(memWr)
  );

endmodule

`default_nettype wire

/* hw/scaleFactorParser.sv */
// Long-block scalefactor parser
`timescale 1ns/1ps
`default_nettype none

module scaleFactorParser
  import mp3FormatPkg::*;
  import decoderBusPkg::*;
#(
  parameter int lineAddrWidth = 10
)
(
  input  logic        Clk,
  input  logic        rst,
  input  logic        start,
  input  sideInfo_t   side,
  input  logic [15:0] window,
  input  logic        windowValid,
  output bitTake_t    take,
  output memWr_t      wr,
  output logic        done
);

  localparam logic [4:0] lastSfb = 5'(numLongSfb - 1);

  slenPair_t  slens;
  logic       busy;
  logic [4:0] sfb;
  logic [2:0] slen;
  logic [1:0] group;
  logic       reuse;
  logic       advance;
  logic [3:0] value;

  assign slens = slenPair(side.scalefacCompress);

  // scfsi band groups 0-5, 6-10, 11-15, 16-20
  always_comb
  begin
    if (sfb < 5'd6)
      group = 2'd0;
    else if (sfb < 5'd11)
      group = 2'd1;
    else if (sfb < 5'd16)
      group = 2'd2;
    else
      group = 2'd3;
    slen = (sfb < 5'd11) ? slens.slen0 : slens.slen1;
  end

  assign reuse   = side.granule && side.scfsi[group];     // keep granule 0 value
  assign advance = busy && (reuse || slen == 3'd0 || windowValid);
  assign value   = (slen == 3'd0) ? 4'd0 : window[15:12] >> (3'd4 - slen);

  always_comb
  begin
    take.take  = busy && !reuse && slen != 3'd0 && windowValid;
    take.count = {2'b00, slen};
  end

  always_comb
  begin
    wr.valid = advance && !reuse;
    wr.addr  = {1'b1, side.channel, lineAddrWidth'(sfb)};
    wr.data  = {12'h000, value};
  end

  // one band per cycle
  always_ff @(posedge Clk)
  begin
    if (rst)
    begin
      busy <= 1'b0;
      sfb  <= '0;
      done <= 1'b0;
    end
    else
    begin
      done <= 1'b0;
      if (start)
      begin
        busy <= 1'b1;
        sfb  <= '0;
      end
      else if (advance)
      begin
        sfb <= sfb + 5'd1;
        if (sfb == lastSfb)
        begin
          busy <= 1'b0;
          done <= 1'b1;
        end
      end
    end
  end

endmodule

`default_nettype wire

/* sim.f */
hw/mp3FormatPkg.sv
hw/decoderBusPkg.sv
hw/bitReservoir.sv
hw/scaleFactorParser.sv
hw/count1Decoder.sv
hw/granuleSequencer.sv
hw/mp3GranuleDecoder.sv
tb/granuleDecoderTb.sv

/* tb/granuleDecoderTb.sv */
// Granule decoder testbench
`timescale 1ns/1ps
`default_nettype none

module granuleDecoderTb
  import mp3FormatPkg::*;
  import decoderBusPkg::*;
();

  localparam int timeoutCycles = 20000;
  localparam int goldenWords   = 256;

  logic       Clk;
  logic       rst;
  logic       startReq;
  sideInfo_t  side;
  logic       doneAck;
  logic       fetchReq;
  logic       fetchAck;
  logic [7:0] fetchData;
  memWr_t     memWr;

  logic [31:0] golden [0:goldenWords-1];
  logic [15:0] model [0:4095];
  logic [7:0]  stream [$];
  int          granStart [$];
  int          streamPos;
  logic [16:0] lfsr;
  int          waitLeft;
  logic        armed;
  logic        granuleActive;
  logic        ackSeen;
  logic        reqSeen;

  mp3GranuleDecoder #(.sampleWidth(16), .lineAddrWidth(10)) dut (
    .Clk(Clk), .rst(rst), .startReq(startReq), .side(side), .doneAck(doneAck),
    .fetchReq(fetchReq), .fetchAck(fetchAck), .fetchData(fetchData), .memWr(memWr)
  );

  always #50 Clk = ~Clk;

  // 17-bit Fibonacci LFSR with taps 17 and 14
  function automatic logic [16:0] lfsrStep(input logic [16:0] state);
    return {state[15:0], state[16] ^ state[13]};
  endfunction

  task automatic stopOnFailure();
    $display("test failed");
    $fatal(1);
  endtask

  task automatic failRun(input string why);
    $display("%s", why);
    stopOnFailure();
  endtask

  task automatic compareValue(input string name, input logic [31:0] got,
                              input logic [31:0] expected);
    if (got !== expected)
    begin
      $display("Error: %s = %h, expected %h", name, got, expected);
      stopOnFailure();
    end
  endtask

  task automatic waitForDoneAck(input logic level);
    int cycles;
    cycles = 0;
    @(negedge Clk);
    while (doneAck !== level && cycles < timeoutCycles)
    begin
      @(negedge Clk);
      cycles++;
    end
    if (doneAck !== level)
      failRun($sformatf("timeout while waiting for doneAck to become %0b", level));
  endtask

  // ************************************************************************
  // byte source with random ack delay
  // ************************************************************************
  always @(posedge Clk)
  begin
    if (rst)
    begin
      fetchAck <= 1'b0;
      armed    = 1'b0;
    end
    else if (fetchAck)
    begin
      if (!fetchReq)
        fetchAck <= 1'b0;            // req released
    end
    else if (fetchReq)
    begin
      if (!armed)
      begin
        waitLeft = lfsr[16];
        lfsr     = lfsrStep(lfsr);
        waitLeft = waitLeft * 2 + lfsr[16];
        lfsr     = lfsrStep(lfsr);
        armed    = 1'b1;
      end
      if (waitLeft == 0)
      begin
        fetchData <= (streamPos < stream.size()) ? stream[streamPos] : 8'h00;
        fetchAck  <= 1'b1;
        streamPos++;
        armed = 1'b0;
      end
      else
        waitLeft--;
    end
  end

  // memory model and protocol monitor
  always @(posedge Clk)
  begin
    if (memWr.valid)
      model[memWr.addr] <= memWr.data;
    if (!rst)
    begin
      if (memWr.valid && (!granuleActive || doneAck))
        failRun("memory write seen outside a granule");
      else if (doneAck && !ackSeen && !startReq)
        failRun("doneAck rose without startReq");
      else if (!doneAck && ackSeen && startReq)
        failRun("doneAck dropped while startReq was still high");
      else if (fetchReq && !reqSeen && fetchAck)
        failRun("fetchReq rose while fetchAck was still high");
    end
    ackSeen = doneAck;
    reqSeen = fetchReq;
  end

  task automatic loadGolden();
    int ptr;
    int count;
    ptr = 1;
    $readmemh("tb/granuleGolden.mem", golden);
    if (golden[0] === 'x || golden[0] == 0 || golden[0] > 8)
      failRun("golden file is missing or has a bad granule count");
    for (int g = 0; g < golden[0]; g++)
    begin
      granStart.push_back(ptr);
      count = golden[ptr + 1];
      for (int i = 0; i < count; i++)
        stream.push_back(golden[ptr + 2 + i][7:0]);
      ptr = ptr + 2 + count;
      ptr = ptr + 1 + golden[ptr];   // scalefactors
      ptr = ptr + 1 + golden[ptr];   // spectral lines
    end
  endtask

  // ************************************************************************
  // run one granule and compare memory against golden
  // ************************************************************************
  task automatic runGranule(input int g);
    int          ptr;
    int          count;
    logic [31:0] sideWord;
    logic [31:0] entry;
    logic [15:0] expLine [0:575];
    logic [11:0] addr;
    ptr      = granStart[g];
    sideWord = golden[ptr];
    ptr      = ptr + 2 + golden[ptr + 1];

    @(posedge Clk);
    side          <= sideWord[21:0];
    startReq      <= 1'b1;
    granuleActive <= 1'b1;
    waitForDoneAck(1'b1);
    granuleActive <= 1'b0;
    @(posedge Clk);
    startReq <= 1'b0;
    waitForDoneAck(1'b0);

    count = golden[ptr];
    for (int i = 0; i < count; i++)
    begin
      entry = golden[ptr + 1 + i];
      compareValue($sformatf("model[%03h]", entry[27:16]), model[entry[27:16]], entry[15:0]);
    end
    ptr = ptr + 1 + count;

    for (int l = 0; l < numLines; l++)
      expLine[l] = 16'h0000;        // unlisted lines are zero
    count = golden[ptr];
    for (int i = 0; i < count; i++)
    begin
      entry                  = golden[ptr + 1 + i];
      expLine[entry[25:16]] = entry[15:0];
    end
    for (int l = 0; l < numLines; l++)
    begin
      addr = {1'b0, sideWord[20], 10'(l)};
      compareValue($sformatf("model[%03h]", addr), model[addr], expLine[l]);
    end
  endtask

  initial
  begin
    Clk           = 1'b0;
    rst           = 1'b1;
    startReq      = 1'b0;
    side          = '0;
    fetchAck      = 1'b0;
    fetchData     = 8'h00;
    lfsr          = 17'd81822;
    streamPos     = 0;
    granuleActive = 1'b0;
    ackSeen       = 1'b0;
    reqSeen       = 1'b0;
    for (int a = 0; a < 4096; a++)
      model[a] = {4'ha, 12'(a)};    // fill follows address
    loadGolden();

    repeat (3) @(posedge Clk);
    @(negedge Clk);
    compareValue("doneAck", doneAck, 0);
    compareValue("fetchReq", fetchReq, 0);
    compareValue("memWr.valid", memWr.valid, 0);
    @(posedge Clk);
    rst <= 1'b0;
    repeat (20) @(posedge Clk);     // reservoir fills while idle

    for (int g = 0; g < granStart.size(); g++)
      runGranule(g);

    $display("test passed");
    $finish;
  end

endmodule

`default_nettype wire

/* tb/granuleGolden.mem */
// 32-bit hex words: granule count, then per granule side info, byte count, bytes,
// scalefactor count and {addr,data} words, nonzero line count and {addr,data} words
3
// granule 0, channel 0, compress 6, part23 52
003460 7
B2 FC 9B 0E 0B F5 36
15
08000001 08010000 08020001 08030001 08040000 08050000 08060001
08070000 08080001 08090001 080A0001 080B0003 080C0002 080D0001
080E0000 080F0003 08100001 08110002 08120000 08130001 08140003
6
00000001 0001FFFF 00020001 0003FFFF 0009FFFF 000B0001
// granule 1, channel 0, scfsi 0101, part23 22
201665 3
1D 2F 8F
15
08000001 08010000 08020001 08030001 08040000 08050000 08060000
08070001 08080001 08090000 080A0000 080B0003 080C0002 080D0001
080E0000 080F0003 08100000 08110003 08120002 08130002 08140001
1
0000FFFF
// granule 2, channel 1, compress 15, part23 81
1051FF A
C2 06 97 1C A6 8E B1 70 7C 20
15
0C000003 0C01000F 0C020000 0C030008 0C040001 0C05000A 0C060005
0C07000C 0C080007 0C090002 0C0A0009 0C0B0005 0C0C0000 0C0D0007
0C0E0002 0C0F0006 0C100001 0C110003 0C120004 0C130000 0C140007
2
04020001 04030001
